/* verilog/nic_ft_pkg.sv */
package nic_ft_pkg;

	// One GMII data byte
	typedef logic [7:0] gmii_data_t;

	// PHY speed code as reported by the in-band status
	typedef enum logic [1:0] {
		SPEED_10   = 2'd0,
		SPEED_100  = 2'd1,
		SPEED_1000 = 2'd2
	} link_speed_e;

	// Index of a PHY port
	typedef logic port_sel_t;

	// Per-PHY link status, duplex high means full
	typedef struct packed {
		logic        up;
		link_speed_e speed;
		logic        duplex;
	} phy_status_t;

	// GMII word, en is rx data valid or tx enable
	typedef struct packed {
		gmii_data_t data;
		logic       en;
		logic       er;
	} gmii_bus_t;

	// Merged link state seen by the MAC
	typedef struct packed {
		logic        up;
		link_speed_e speed;
		logic        duplex;
		port_sel_t   active_port;
	} link_state_t;

	typedef enum logic [1:0] {
		ST_NO_LINK = 2'd0,
		ST_PORT0   = 2'd1,
		ST_PORT1   = 2'd2
	} failover_state_e;

	// Cycles a synchronized status must hold before it is accepted
	localparam int DEBOUNCE_CYCLES_DEF = 4096;

endpackage

/* verilog/link_status_filter.sv */
`timescale 1ns/1ps

module link_status_filter #(
	parameter int DEBOUNCE_CYCLES = nic_ft_pkg::DEBOUNCE_CYCLES_DEF
) (
	input  logic                    pci_clk,
	input  logic                    rst_n_i,
	input  nic_ft_pkg::phy_status_t phy0_status_i,
	input  nic_ft_pkg::phy_status_t phy1_status_i,
	output nic_ft_pkg::phy_status_t filt0_o,
	output nic_ft_pkg::phy_status_t filt1_o
);
	import nic_ft_pkg::*;

	localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

	typedef logic [CNT_W-1:0] cnt_t;

	localparam cnt_t CNT_DONE = cnt_t'(DEBOUNCE_CYCLES);

	phy_status_t status_in [2];
	phy_status_t sync1_q [2];
	phy_status_t sync2_q [2];
	phy_status_t filt_q [2];
	cnt_t        stable_cnt_q [2];

	assign status_in[0] = phy0_status_i;
	assign status_in[1] = phy1_status_i;

	//////////////////////////////////////////////////
	// Per-port synchronizer and debounce

	for (genvar p = 0; p < 2; p++) begin : g_port
		always_ff @(posedge pci_clk) begin
			if (!rst_n_i) begin
				sync1_q[p]      <= '0;
				sync2_q[p]      <= '0;
				filt_q[p]       <= '0;
				stable_cnt_q[p] <= '0;
			end else begin
				// Status bits settle together once debounced
				sync1_q[p] <= status_in[p];
				sync2_q[p] <= sync1_q[p];

				// Count cycles the synchronized value has held, including this one
				if (sync1_q[p] != sync2_q[p]) begin
					stable_cnt_q[p] <= cnt_t'(1);
				end else if (stable_cnt_q[p] != CNT_DONE) begin
					stable_cnt_q[p] <= stable_cnt_q[p] + cnt_t'(1);
				end

				if (stable_cnt_q[p] == CNT_DONE) begin
					filt_q[p] <= sync2_q[p];
				end
			end
		end
	end

	assign filt0_o = filt_q[0];
	assign filt1_o = filt_q[1];

endmodule

/* verilog/port_failover.sv */
`timescale 1ns/1ps

module port_failover (
	input  logic                    pci_clk,
	input  logic                    rst_n_i,
	input  nic_ft_pkg::phy_status_t filt0_i,
	input  nic_ft_pkg::phy_status_t filt1_i,
	output nic_ft_pkg::link_state_t link_o,
	output logic                    link_change_o
);
	import nic_ft_pkg::*;

	failover_state_e state_q;
	failover_state_e state_d;
	link_state_t     link_q;
	link_state_t     link_d;
	phy_status_t     act_status;

	//////////////////////////////////////////////////
	// Port selection

	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_NO_LINK: begin
				// Port 0 preferred when both come up together
				if (filt0_i.up) begin
					state_d = ST_PORT0;
				end else if (filt1_i.up) begin
					state_d = ST_PORT1;
				end
			end
			ST_PORT0: begin
				if (!filt0_i.up) begin
					state_d = filt1_i.up ? ST_PORT1 : ST_NO_LINK;
				end
			end
			ST_PORT1: begin
				if (!filt1_i.up) begin
					state_d = filt0_i.up ? ST_PORT0 : ST_NO_LINK;
				end
			end
			default: begin
				state_d = ST_NO_LINK;
			end
		endcase
	end

	// Merged link state, port index held while down
	always_comb begin
		link_d             = '0;
		link_d.active_port = link_q.active_port;
		if (state_d == ST_PORT0) begin
			link_d.active_port = 1'b0;
		end else if (state_d == ST_PORT1) begin
			link_d.active_port = 1'b1;
		end

		act_status = link_d.active_port ? filt1_i : filt0_i;
		if (state_d != ST_NO_LINK) begin
			link_d.up     = 1'b1;
			link_d.speed  = act_status.speed;
			link_d.duplex = act_status.duplex;
		end
	end

	always_ff @(posedge pci_clk) begin
		if (!rst_n_i) begin
			state_q       <= ST_NO_LINK;
			link_q        <= '0;
			link_change_o <= 1'b0;
		end else begin
			state_q       <= state_d;
			link_q        <= link_d;
			link_change_o <= (link_d != link_q);
		end
	end

	assign link_o = link_q;

	// Link only reported on a port whose filtered status was up
	a_active_port_up: assert property (@(posedge pci_clk) disable iff (!rst_n_i)
		link_o.up |-> (link_o.active_port ? $past(filt1_i.up) : $past(filt0_i.up)));

endmodule

/* verilog/gmii_port_mux.sv */
`timescale 1ns/1ps

module gmii_port_mux (
	input  logic                    pci_clk,
	input  logic                    rst_n_i,
	input  nic_ft_pkg::link_state_t link_i,
	input  nic_ft_pkg::gmii_bus_t   phy0_rx_i,
	input  nic_ft_pkg::gmii_bus_t   phy1_rx_i,
	input  nic_ft_pkg::gmii_bus_t   mac_tx_i,
	output nic_ft_pkg::gmii_bus_t   mac_rx_o,
	output nic_ft_pkg::gmii_bus_t   phy0_tx_o,
	output nic_ft_pkg::gmii_bus_t   phy1_tx_o,
	output logic                    sdp6_o,
	output logic                    sdp7_o
);
	import nic_ft_pkg::*;

	gmii_bus_t  rx_sel;
	gmii_data_t rx_data_q;
	logic       rx_en_q;
	logic       rx_er_q;
	gmii_data_t tx_data_q [2];
	logic       tx_en_q [2];
	logic       tx_er_q [2];
	logic       tx_route [2];

	//////////////////////////////////////////////////
	// Receive path

	assign rx_sel = link_i.active_port ? phy1_rx_i : phy0_rx_i;

	always_ff @(posedge pci_clk) begin
		rx_data_q <= rx_sel.data;
	end

	always_ff @(posedge pci_clk) begin
		if (!rst_n_i) begin
			rx_en_q <= 1'b0;
			rx_er_q <= 1'b0;
		end else begin
			rx_en_q <= rx_sel.en & link_i.up;
			rx_er_q <= rx_sel.er & link_i.up;
		end
	end

	assign mac_rx_o = '{data: rx_data_q, en: rx_en_q, er: rx_er_q};

	//////////////////////////////////////////////////
	// Transmit steering, idle words on the standby port

	for (genvar p = 0; p < 2; p++) begin : g_tx
		assign tx_route[p] = link_i.up && (link_i.active_port == port_sel_t'(p));

		always_ff @(posedge pci_clk) begin
			tx_data_q[p] <= tx_route[p] ? mac_tx_i.data : '0;
		end

		always_ff @(posedge pci_clk) begin
			if (!rst_n_i) begin
				tx_en_q[p] <= 1'b0;
				tx_er_q[p] <= 1'b0;
			end else begin
				tx_en_q[p] <= tx_route[p] & mac_tx_i.en;
				tx_er_q[p] <= tx_route[p] & mac_tx_i.er;
			end
		end
	end

	assign phy0_tx_o = '{data: tx_data_q[0], en: tx_en_q[0], er: tx_er_q[0]};
	assign phy1_tx_o = '{data: tx_data_q[1], en: tx_en_q[1], er: tx_er_q[1]};

	// Software-definable pins tell which port carries the link
	assign sdp6_o = link_i.up && !link_i.active_port;
	assign sdp7_o = link_i.up && link_i.active_port;

	a_single_tx_port: assert property (@(posedge pci_clk) disable iff (!rst_n_i)
		!(phy0_tx_o.en && phy1_tx_o.en));

endmodule

/* verilog/nic_ft_top.sv */
`timescale 1ns/1ps

module nic_ft_top #(
	parameter int DEBOUNCE_CYCLES = nic_ft_pkg::DEBOUNCE_CYCLES_DEF
) (
	input  logic                    pci_clk,
	input  logic                    rst_n_i,

	// PHY side
	input  nic_ft_pkg::phy_status_t phy0_status_i,
	input  nic_ft_pkg::phy_status_t phy1_status_i,
	input  nic_ft_pkg::gmii_bus_t   phy0_rx_i,
	input  nic_ft_pkg::gmii_bus_t   phy1_rx_i,
	output nic_ft_pkg::gmii_bus_t   phy0_tx_o,
	output nic_ft_pkg::gmii_bus_t   phy1_tx_o,

	// MAC side
	input  nic_ft_pkg::gmii_bus_t   mac_tx_i,
	output nic_ft_pkg::gmii_bus_t   mac_rx_o,
	output nic_ft_pkg::link_state_t link_o,
	output logic                    link_change_o,
	output logic                    sdp6_o,
	output logic                    sdp7_o
);
	import nic_ft_pkg::*;

	phy_status_t filt0;
	phy_status_t filt1;
	link_state_t link;

	link_status_filter #(
		.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
	) status_filter_i (
		.pci_clk(pci_clk),
		.rst_n_i(rst_n_i),
		.phy0_status_i(phy0_status_i),
		.phy1_status_i(phy1_status_i),
		.filt0_o(filt0),
		.filt1_o(filt1)
	);

	port_failover failover_i (
		.pci_clk(pci_clk),
		.rst_n_i(rst_n_i),
		.filt0_i(filt0),
		.filt1_i(filt1),
		.link_o(link),
		.link_change_o(link_change_o)
	);

	gmii_port_mux port_mux_i (
		.pci_clk(pci_clk),
		.rst_n_i(rst_n_i),
		.link_i(link),
		.phy0_rx_i(phy0_rx_i),
		.phy1_rx_i(phy1_rx_i),
		.mac_tx_i(mac_tx_i),
		.mac_rx_o(mac_rx_o),
		.phy0_tx_o(phy0_tx_o),
		.phy1_tx_o(phy1_tx_o),
		.sdp6_o(sdp6_o),
		.sdp7_o(sdp7_o)
	);

	assign link_o = link;

endmodule

/* include/tb_nic_ft_checks.svh */
`ifndef TB_NIC_FT_CHECKS_SVH
`define TB_NIC_FT_CHECKS_SVH

// Error counters, one per kind of compare
int link_errors = 0;
int bus_errors  = 0;
int bit_errors  = 0;

// Galois LFSR for random GMII words
logic [31:0] lfsr_state = 32'h9eebf760;

function automatic logic [31:0] lfsr_step(input logic [31:0] state);
	logic [31:0] next;
	next = state >> 1;
	if (state[0]) begin
		next = next ^ 32'hd000_0001;
	end
	return next;
endfunction

// One LFSR step per bit taken, LSB first
task automatic lfsr_take(input int nbits, output logic [31:0] bits);
	bits = '0;
	for (int i = 0; i < nbits; i++) begin
		bits[i]    = lfsr_state[0];
		lfsr_state = lfsr_step(lfsr_state);
	end
endtask

//////////////////////////////////////////////////
// Compare tasks

task automatic check_link(input string name, input nic_ft_pkg::link_state_t got,
		input nic_ft_pkg::link_state_t exp);
	if (got !== exp) begin
		$display("[ERROR] %s: got %h expected %h", name, got, exp);
		link_errors++;
	end
endtask

task automatic check_bus(input string name, input nic_ft_pkg::gmii_bus_t got,
		input nic_ft_pkg::gmii_bus_t exp);
	if (got !== exp) begin
		$display("[ERROR] %s: got %h expected %h", name, got, exp);
		bus_errors++;
	end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
	if (got !== exp) begin
		$display("[ERROR] %s: got %h expected %h", name, got, exp);
		bit_errors++;
	end
endtask

`endif

/* test/tb_nic_ft.sv */
`timescale 1ns/1ps

module tb_nic_ft;
	import nic_ft_pkg::*;

	`include "tb_nic_ft_checks.svh"

	localparam int DEB_CYCLES  = 8;
	localparam int WAIT_CYCLES = 4 * DEB_CYCLES;
	localparam int GLITCH_LEN  = DEB_CYCLES - 2;
	localparam int NUM_WORDS   = 16;

	logic        pci_clk = 1'b0;
	logic        rst_n_i;
	phy_status_t phy0_status_i;
	phy_status_t phy1_status_i;
	gmii_bus_t   phy0_rx_i;
	gmii_bus_t   phy1_rx_i;
	gmii_bus_t   mac_tx_i;
	gmii_bus_t   mac_rx_o;
	gmii_bus_t   phy0_tx_o;
	gmii_bus_t   phy1_tx_o;
	link_state_t link_o;
	logic        link_change_o;
	logic        sdp6_o;
	logic        sdp7_o;

	int timeout_errors = 0;
	int total_errors;

	nic_ft_top #(
		.DEBOUNCE_CYCLES(DEB_CYCLES)
	) DUT (
		.pci_clk(pci_clk),
		.rst_n_i(rst_n_i),
		.phy0_status_i(phy0_status_i),
		.phy1_status_i(phy1_status_i),
		.phy0_rx_i(phy0_rx_i),
		.phy1_rx_i(phy1_rx_i),
		.phy0_tx_o(phy0_tx_o),
		.phy1_tx_o(phy1_tx_o),
		.mac_tx_i(mac_tx_i),
		.mac_rx_o(mac_rx_o),
		.link_o(link_o),
		.link_change_o(link_change_o),
		.sdp6_o(sdp6_o),
		.sdp7_o(sdp7_o)
	);

	always #50 pci_clk = ~pci_clk;

	//////////////////////////////////////////////////
	// Helpers

	task automatic random_word(output gmii_bus_t word);
		logic [31:0] bits;
		lfsr_take(10, bits);
		word = gmii_bus_t'(bits[9:0]);
	endtask

	// Returns on the falling edge where the pulse is seen
	task automatic wait_link_change(input string cause);
		int n;
		n = 0;
		@(negedge pci_clk);
		while (link_change_o !== 1'b1 && n < WAIT_CYCLES) begin
			@(negedge pci_clk);
			n++;
		end
		if (link_change_o !== 1'b1) begin
			$display("Timeout: no link change pulse within %0d cycles after %s",
				WAIT_CYCLES, cause);
			timeout_errors++;
		end
	endtask

	task automatic watch_stable(input link_state_t exp);
		bit failed;
		failed = 1'b0;
		for (int i = 0; i < WAIT_CYCLES && !failed; i++) begin
			@(negedge pci_clk);
			if (link_o !== exp || link_change_o !== 1'b0) begin
				check_link("link_o", link_o, exp);
				check_bit("link_change_o", link_change_o, 1'b0);
				failed = 1'b1;
			end
		end
	endtask

	task automatic check_pins(input logic exp6, input logic exp7);
		check_bit("sdp6_o", sdp6_o, exp6);
		check_bit("sdp7_o", sdp7_o, exp7);
	endtask

	task automatic check_ctrl_low();
		check_bit("mac_rx_o.en", mac_rx_o.en, 1'b0);
		check_bit("mac_rx_o.er", mac_rx_o.er, 1'b0);
		check_bit("phy0_tx_o.en", phy0_tx_o.en, 1'b0);
		check_bit("phy0_tx_o.er", phy0_tx_o.er, 1'b0);
		check_bit("phy1_tx_o.en", phy1_tx_o.en, 1'b0);
		check_bit("phy1_tx_o.er", phy1_tx_o.er, 1'b0);
	endtask

	//////////////////////////////////////////////////
	// Directed tests

	task automatic test_reset_state();
		@(negedge pci_clk);
		check_link("link_o", link_o, '0);
		check_bit("link_change_o", link_change_o, 1'b0);
		check_pins(1'b0, 1'b0);
		check_ctrl_low();
	endtask

	task automatic test_first_link();
		link_state_t exp;
		exp = '{up: 1'b1, speed: SPEED_1000, duplex: 1'b1, active_port: 1'b1};
		phy1_status_i = '{up: 1'b1, speed: SPEED_1000, duplex: 1'b1};
		wait_link_change("port 1 up");
		check_link("link_o", link_o, exp);
		check_pins(1'b0, 1'b1);
		@(negedge pci_clk);
		check_bit("link_change_o", link_change_o, 1'b0);

		// No switch back to port 0
		phy0_status_i = '{up: 1'b1, speed: SPEED_100, duplex: 1'b0};
		watch_stable(exp);
		check_pins(1'b0, 1'b1);
	endtask

	task automatic test_failover();
		link_state_t exp;
		exp = '{up: 1'b1, speed: SPEED_100, duplex: 1'b0, active_port: 1'b0};
		phy1_status_i = '0;
		wait_link_change("port 1 down");
		check_link("link_o", link_o, exp);
		check_pins(1'b1, 1'b0);
		@(negedge pci_clk);
		check_bit("link_change_o", link_change_o, 1'b0);

		phy1_status_i = '{up: 1'b1, speed: SPEED_1000, duplex: 1'b1};
		watch_stable(exp);
	endtask

	// One word in flight on each path, checked a cycle after it is driven
	task automatic test_data_routing(input port_sel_t port);
		gmii_bus_t rx0;
		gmii_bus_t rx1;
		gmii_bus_t tx;
		gmii_bus_t exp_rx;
		gmii_bus_t exp_tx;
		for (int k = 0; k <= NUM_WORDS; k++) begin
			if (k > 0) begin
				@(negedge pci_clk);
				check_bus("mac_rx_o", mac_rx_o, exp_rx);
				check_bus("phy0_tx_o", phy0_tx_o, (port == 1'b0) ? exp_tx : '0);
				check_bus("phy1_tx_o", phy1_tx_o, (port == 1'b1) ? exp_tx : '0);
			end
			if (k < NUM_WORDS) begin
				random_word(rx0);
				random_word(rx1);
				random_word(tx);
				phy0_rx_i = rx0;
				phy1_rx_i = rx1;
				mac_tx_i  = tx;
				exp_rx    = (port == 1'b0) ? rx0 : rx1;
				exp_tx    = tx;
			end
		end
		phy0_rx_i = '0;
		phy1_rx_i = '0;
		mac_tx_i  = '0;
	endtask

	task automatic test_glitch_rejection();
		link_state_t exp;
		exp = '{up: 1'b1, speed: SPEED_100, duplex: 1'b0, active_port: 1'b0};
		fork
			watch_stable(exp);
			begin
				phy0_status_i.up = 1'b0;
				repeat (GLITCH_LEN) @(negedge pci_clk);
				phy0_status_i.up = 1'b1;
			end
		join
	endtask

	task automatic test_total_loss();
		gmii_bus_t word;
		phy0_status_i = '0;
		phy1_status_i = '0;
		wait_link_change("both ports down");
		check_link("link_o", link_o, '0);
		check_pins(1'b0, 1'b0);

		// Words with en and er high must not pass
		for (int k = 0; k < 8; k++) begin
			random_word(word);
			word.en   = 1'b1;
			word.er   = 1'b1;
			phy0_rx_i = word;
			phy1_rx_i = word;
			mac_tx_i  = word;
			@(negedge pci_clk);
			check_ctrl_low();
		end
		phy0_rx_i = '0;
		phy1_rx_i = '0;
		mac_tx_i  = '0;
	endtask

	//////////////////////////////////////////////////
	// Main sequence

	initial begin
		rst_n_i       = 1'b0;
		phy0_status_i = '0;
		phy1_status_i = '0;
		phy0_rx_i     = '0;
		phy1_rx_i     = '0;
		mac_tx_i      = '0;
		repeat (2) @(posedge pci_clk);
		@(negedge pci_clk);
		rst_n_i = 1'b1;

		test_reset_state();
		test_first_link();
		test_failover();
		test_data_routing(1'b0);
		test_glitch_rejection();
		test_total_loss();

		total_errors = link_errors + bus_errors + bit_errors + timeout_errors;
		$display("Errors: link %0d, bus %0d, bit %0d, timeout %0d",
			link_errors, bus_errors, bit_errors, timeout_errors);
		if (total_errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

/* sim.f */
+incdir+include
verilog/nic_ft_pkg.sv
verilog/link_status_filter.sv
verilog/port_failover.sv
verilog/gmii_port_mux.sv
verilog/nic_ft_top.sv
test/tb_nic_ft.sv

/* Bender.yml */
package:
  name: nic_ft

sources:
  - files:
      - verilog/nic_ft_pkg.sv
      - verilog/link_status_filter.sv
      - verilog/port_failover.sv
      - verilog/gmii_port_mux.sv
      - verilog/nic_ft_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/tb_nic_ft.sv
